// File: files.f
+incdir+include
logic/ahbPkg.sv
logic/ahbMasterPort.sv
logic/ahbArbiter.sv
logic/ahbWaitTimer.sv
logic/ahbSramSlave.sv
logic/ahbSubsystem.sv
verif/ahbSubsystemTb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and scan the log for a failure
verilator --binary --timing --assert --timescale 1ns/1ns --top-module ahbSubsystemTb -f files.f \
	&& ./obj_dir/VahbSubsystemTb > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0

// File: verif/ahbSubsystemTb.sv
`timescale 1ns/1ns
`include "ahb_params.svh"

module ahbSubsystemTb;

	localparam int numDirected = 8;
	localparam int numRandom = 20;
	localparam int numEntries = numDirected + numRandom;
	localparam int cycleLimit = 40 * numEntries + 50;

	localparam logic [1:0] opNone = 2'd0;
	localparam logic [1:0] opRead = 2'd1;
	localparam logic [1:0] opWrite = 2'd2;

	typedef struct packed {
		logic [2:0]  testId;
		logic        together; // both masters start in the same cycle
		logic [1:0]  op0;
		logic [1:0]  op1;
		logic [31:0] addr0;
		logic [31:0] addr1;
		logic [31:0] data0;
		logic [31:0] data1;
		logic [31:0] exp0;
		logic [31:0] exp1;
	} entryT;

	logic            clock;
	logic            rstN;
	ahbPkg::localReq req0;
	ahbPkg::localReq req1;
	logic [31:0]     readData0;
	logic [31:0]     readData1;
	logic            ready0;
	logic            ready1;

	entryT       stimTable [numEntries];
	logic [31:0] refMem [`MEM_WORDS];   // reference memory
	logic        refKnown [`MEM_WORDS];
	logic [31:0] randState;
	int          entryCount;
	int          passCount;
	int          failCount;
	int          cycleCount;

	ahbSubsystem uut (
		.clock     (clock),
		.rstN      (rstN),
		.req0      (req0),
		.req1      (req1),
		.readData0 (readData0),
		.readData1 (readData1),
		.ready0    (ready0),
		.ready1    (ready1)
	);

	initial clock = 1'b0;
	always #4 clock = ~clock;

	// **************************************************
	// helpers
	// **************************************************

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int wordIndex(input logic [31:0] addr);
		return int'((addr >> 2) % `MEM_WORDS); // bits above bit 1, modulo depth
	endfunction

	function automatic ahbPkg::localReq makeReq(input logic [1:0] op, input logic [31:0] addr,
		input logic [31:0] data);
		ahbPkg::localReq r;
		r.read = (op == opRead);
		r.write = (op == opWrite);
		r.enable = 1'b1;
		r.address = addr;
		r.writeData = data;
		return r;
	endfunction

	function automatic string testName(input logic [2:0] id);
		case (id)
			3'd1: return "reset values";
			3'd2: return "single write and read";
			3'd3: return "simultaneous writes";
			3'd4: return "simultaneous reads";
			3'd5: return "address wrap";
			default: return "random traffic";
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		assert (actual === expected) begin
			passCount = passCount + 1;
		end else begin
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			failCount = failCount + 1;
		end
	endtask

	task automatic reportTest(input logic [2:0] id, input int failsBefore);
		if (failCount == failsBefore) begin
			$display("test %0d %s: ok", id, testName(id));
		end else begin
			$display("test %0d %s: %0d errors", id, testName(id), failCount - failsBefore);
		end
	endtask

	// reads are predicted before the entry's own writes land
	task automatic addEntry(input logic [2:0] testId, input logic together,
		input logic [1:0] op0, input logic [31:0] addr0, input logic [31:0] data0,
		input logic [1:0] op1, input logic [31:0] addr1, input logic [31:0] data1);
		entryT e;
		e.testId = testId;
		e.together = together;
		e.op0 = op0;
		e.op1 = op1;
		e.addr0 = addr0;
		e.addr1 = addr1;
		e.data0 = data0;
		e.data1 = data1;
		e.exp0 = refMem[wordIndex(addr0)];
		e.exp1 = refMem[wordIndex(addr1)];
		if (op0 == opWrite) begin
			refMem[wordIndex(addr0)] = data0;
			refKnown[wordIndex(addr0)] = 1'b1;
		end
		if (op1 == opWrite) begin
			refMem[wordIndex(addr1)] = data1;
			refKnown[wordIndex(addr1)] = 1'b1;
		end
		stimTable[entryCount] = e;
		entryCount = entryCount + 1;
	endtask

	task automatic addRandomEntries();
		logic [31:0] r;
		logic [31:0] a0;
		logic [31:0] a1;
		logic [31:0] d0;
		logic [31:0] d1;
		logic [1:0]  op0;
		logic [1:0]  op1;
		for (int i = 0; i < numRandom; i++) begin
			randState = lcgNext(randState);
			r = randState;
			op0 = 2'((r >> 8) % 32'd3);
			op1 = 2'((r >> 12) % 32'd3);
			a0 = {23'd0, r[26], 1'b0, r[20:16], 2'b00}; // lower half, sometimes +256
			a1 = {24'd0, 1'b1, r[25:21], 2'b00};        // upper half
			if (op0 == opRead && !refKnown[wordIndex(a0)]) begin
				op0 = opWrite; // never read a word that was not written
			end
			if (op1 == opRead && !refKnown[wordIndex(a1)]) begin
				op1 = opWrite;
			end
			randState = lcgNext(randState);
			d0 = randState;
			randState = lcgNext(randState);
			d1 = randState;
			addEntry(3'd6, r[30], op0, a0, d0, op1, a1, d1);
		end
	endtask

	// **************************************************
	// transfer sequencing
	// **************************************************

	task automatic runMasters(input entryT e, input logic go0, input logic go1);
		logic done0;
		logic done1;
		logic low0;
		logic low1;
		done0 = !go0;
		done1 = !go1;
		low0 = 1'b0;
		low1 = 1'b0;
		if (go0) begin
			req0 = makeReq(e.op0, e.addr0, e.data0);
		end
		if (go1) begin
			req1 = makeReq(e.op1, e.addr1, e.data1);
		end
		while (!(done0 && done1)) begin
			@(posedge clock);
			#1;
			if (!done0) begin
				if (!ready0) begin
					low0 = 1'b1;
				end else if (low0) begin
					done0 = 1'b1; // ready dropped and rose again
					req0 = '0;
					if (e.op0 == opRead) begin
						checkValue("readData0", readData0, e.exp0);
					end
				end
			end
			if (!done1) begin
				if (!ready1) begin
					low1 = 1'b1;
				end else if (low1) begin
					done1 = 1'b1;
					req1 = '0;
					if (e.op1 == opRead) begin
						checkValue("readData1", readData1, e.exp1);
					end
				end
			end
		end
	endtask

	task automatic applyEntry(input entryT e);
		logic go0;
		logic go1;
		go0 = (e.op0 != opNone);
		go1 = (e.op1 != opNone);
		if (e.together) begin
			runMasters(e, go0, go1);
		end else begin
			runMasters(e, go0, 1'b0);
			runMasters(e, 1'b0, go1);
		end
		checkValue("ready0", {31'd0, ready0}, 32'd1);
		checkValue("ready1", {31'd0, ready1}, 32'd1);
	endtask

	initial begin
		int  failsBefore;
		logic lastOfTest;
		rstN = 1'b0;
		req0 = '0;
		req1 = '0;
		randState = 32'he385e4a1;
		entryCount = 0;
		passCount = 0;
		failCount = 0;
		for (int i = 0; i < `MEM_WORDS; i++) begin
			refKnown[i] = 1'b0;
		end
		addEntry(3'd2, 1'b0, opWrite, 32'h10, 32'ha5a50001, opNone, 32'h0, 32'h0);
		addEntry(3'd2, 1'b0, opRead, 32'h10, 32'h0, opNone, 32'h0, 32'h0);
		addEntry(3'd2, 1'b0, opNone, 32'h0, 32'h0, opRead, 32'h10, 32'h0);
		addEntry(3'd3, 1'b1, opWrite, 32'h20, 32'h13572468, opWrite, 32'h24, 32'hfeedc0de);
		addEntry(3'd3, 1'b0, opRead, 32'h24, 32'h0, opRead, 32'h20, 32'h0);
		addEntry(3'd4, 1'b1, opRead, 32'h20, 32'h0, opRead, 32'h24, 32'h0);
		addEntry(3'd5, 1'b0, opWrite, 32'h130, 32'h0bad0130, opNone, 32'h0, 32'h0);
		addEntry(3'd5, 1'b1, opRead, 32'h1030, 32'h0, opRead, 32'h30, 32'h0); // both wrap to word 12
		addRandomEntries();

		repeat (10) @(posedge clock);
		#1;
		rstN = 1'b1;
		@(posedge clock);
		#1;
		failsBefore = failCount;
		checkValue("ready0", {31'd0, ready0}, 32'd1);
		checkValue("ready1", {31'd0, ready1}, 32'd1);
		checkValue("readData0", readData0, 32'd0);
		checkValue("readData1", readData1, 32'd0);
		reportTest(3'd1, failsBefore);

		failsBefore = failCount;
		for (int i = 0; i < numEntries; i++) begin
			applyEntry(stimTable[i]);
			lastOfTest = (i == numEntries - 1);
			if (!lastOfTest) begin
				lastOfTest = (stimTable[i + 1].testId != stimTable[i].testId);
			end
			if (lastOfTest) begin
				reportTest(stimTable[i].testId, failsBefore);
				failsBefore = failCount;
			end
		end

		$display("checks: %0d passed, %0d failed", passCount, failCount);
		if (failCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// run limit, counted from time zero so reset is inside the margin
	initial begin
		cycleCount = 0;
		while (cycleCount < cycleLimit) begin
			@(posedge clock);
			cycleCount = cycleCount + 1;
		end
		$display("timeout: a bus transfer never completed within %0d cycles", cycleLimit);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: logic/ahbSubsystem.sv
`timescale 1ns/1ns

module ahbSubsystem (
	input  logic            clock,
	input  logic            rstN,
	input  ahbPkg::localReq req0,
	input  ahbPkg::localReq req1,
	output logic [31:0]     readData0,
	output logic [31:0]     readData1,
	output logic            ready0,
	output logic            ready1
);

	logic                busReq0;
	logic                busReq1;
	logic                grant0;
	logic                grant1;
	ahbPkg::ahbAddrCtrl  addrCtrl0;
	ahbPkg::ahbAddrCtrl  addrCtrl1;
	logic [31:0]         writeData0;
	logic [31:0]         writeData1;
	ahbPkg::ahbAddrCtrl  busAddrCtrl;
	logic [31:0]         busWriteData;
	ahbPkg::ahbSlaveResp slaveResp;

	// **************************************************
	// masters
	// **************************************************

	ahbMasterPort master0 (
		.clock     (clock),
		.rstN      (rstN),
		.req       (req0),
		.grant     (grant0),
		.resp      (slaveResp),
		.readData  (readData0),
		.ready     (ready0),
		.busReq    (busReq0),
		.addrCtrl  (addrCtrl0),
		.writeData (writeData0)
	);

	ahbMasterPort master1 (
		.clock     (clock),
		.rstN      (rstN),
		.req       (req1),
		.grant     (grant1),
		.resp      (slaveResp),
		.readData  (readData1),
		.ready     (ready1),
		.busReq    (busReq1),
		.addrCtrl  (addrCtrl1),
		.writeData (writeData1)
	);

	// **************************************************
	// arbiter and memory slave
	// **************************************************

	ahbArbiter arbiter (
		.clock        (clock),
		.rstN         (rstN),
		.busReq0      (busReq0),
		.busReq1      (busReq1),
		.addrCtrl0    (addrCtrl0),
		.addrCtrl1    (addrCtrl1),
		.writeData0   (writeData0),
		.writeData1   (writeData1),
		.resp         (slaveResp),
		.grant0       (grant0),
		.grant1       (grant1),
		.busAddrCtrl  (busAddrCtrl),
		.busWriteData (busWriteData)
	);

	ahbSramSlave slave (
		.clock     (clock),
		.rstN      (rstN),
		.addrCtrl  (busAddrCtrl),
		.writeData (busWriteData),
		.resp      (slaveResp)
	);

endmodule

// File: logic/ahbSramSlave.sv
`timescale 1ns/1ns
`include "ahb_params.svh"

module ahbSramSlave (
	input  logic                clock,
	input  logic                rstN,
	input  ahbPkg::ahbAddrCtrl  addrCtrl,
	input  logic [31:0]         writeData,
	output ahbPkg::ahbSlaveResp resp
);

	localparam int idxBits = $clog2(`MEM_WORDS);

	logic [31:0]        mem [`MEM_WORDS];
	logic [idxBits-1:0] wordIdx;
	logic               writeFlag;
	logic               valid;    // a data phase is pending
	logic               waiting;
	logic               addrDone;
	logic               dataDone;

	assign addrDone = (addrCtrl.trans == ahbPkg::transNonseq) && !waiting;
	assign dataDone = valid && !waiting;

	// **************************************************
	// address phase register
	// **************************************************

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			valid <= 1'b0;
			writeFlag <= 1'b0;
			wordIdx <= '0;
		end else if (addrDone) begin
			valid <= 1'b1;
			writeFlag <= addrCtrl.write;
			wordIdx <= addrCtrl.addr[idxBits+1:2]; // upper bits dropped, wraps by depth
		end else if (dataDone) begin
			valid <= 1'b0;
		end
	end

	ahbWaitTimer timer (
		.clock   (clock),
		.rstN    (rstN),
		.load    (addrDone),
		.waiting (waiting)
	);

	// **************************************************
	// memory array
	// **************************************************

	always_ff @(posedge clock) begin
		if (dataDone && writeFlag) begin
			mem[wordIdx] <= writeData;
		end
	end

	always_comb begin
		resp.ready = !waiting;
		resp.resp = `RESP_OKAY;
		resp.rdata = mem[wordIdx]; // read straight from the registered index
	end

endmodule

// File: logic/ahbWaitTimer.sv
`timescale 1ns/1ns
`include "ahb_params.svh"

module ahbWaitTimer (
	input  logic clock,
	input  logic rstN,
	input  logic load,
	output logic waiting
);

	// one spare count keeps the width nonzero when there are no wait states
	localparam int cntBits = $clog2(`WAIT_STATES + 2);

	logic [cntBits-1:0] count;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			count <= '0;
		end else if (load) begin
			count <= cntBits'(`WAIT_STATES);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	assign waiting = (count != '0);

endmodule

// File: logic/ahbArbiter.sv
`timescale 1ns/1ns

module ahbArbiter (
	input  logic                clock,
	input  logic                rstN,
	input  logic                busReq0,
	input  logic                busReq1,
	input  ahbPkg::ahbAddrCtrl  addrCtrl0,
	input  ahbPkg::ahbAddrCtrl  addrCtrl1,
	input  logic [31:0]         writeData0,
	input  logic [31:0]         writeData1,
	input  ahbPkg::ahbSlaveResp resp,
	output logic                grant0,
	output logic                grant1,
	output ahbPkg::ahbAddrCtrl  busAddrCtrl,
	output logic [31:0]         busWriteData
);

	logic owner;     // 0 = master 0 holds the grant
	logic dataOwner; // master in the data phase
	logic busy;
	logic addrDone;
	logic dataDone;
	logic ownerReq;
	logic otherReq;

	assign addrDone = (busAddrCtrl.trans == ahbPkg::transNonseq) && resp.ready;
	assign dataDone = busy && resp.ready;

	assign ownerReq = owner ? busReq1 : busReq0;
	assign otherReq = owner ? busReq0 : busReq1;

	// **************************************************
	// grant and data-phase tracking
	// **************************************************

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			owner <= 1'b0;
			dataOwner <= 1'b0;
			busy <= 1'b0;
		end else begin
			if (!busy && !ownerReq && otherReq) begin
				owner <= ~owner; // hand over to the waiting master
			end
			if (addrDone) begin
				dataOwner <= owner;
				busy <= 1'b1; // a new address phase overrides the clear
			end else if (dataDone) begin
				busy <= 1'b0;
			end
		end
	end

	assign grant0 = ~owner;
	assign grant1 = owner;

	// address phase follows the grant, write data follows the data phase
	assign busAddrCtrl = owner ? addrCtrl1 : addrCtrl0;
	assign busWriteData = dataOwner ? writeData1 : writeData0;

endmodule

// File: logic/ahbMasterPort.sv
`timescale 1ns/1ns
`include "ahb_params.svh"

module ahbMasterPort (
	input  logic                clock,
	input  logic                rstN,
	input  ahbPkg::localReq     req,
	input  logic                grant,
	input  ahbPkg::ahbSlaveResp resp,
	output logic [31:0]         readData,
	output logic                ready,
	output logic                busReq,
	output ahbPkg::ahbAddrCtrl  addrCtrl,
	output logic [31:0]         writeData
);

	ahbPkg::masterStateE state;
	ahbPkg::masterStateE nextState;
	logic                wasIdle; // idle on the previous edge
	logic                startRead;
	logic                startWrite;

	assign ready = (state == ahbPkg::stateIdle);
	assign busReq = req.enable && ready && wasIdle;

	// a transfer starts only from a granted, requesting idle master
	assign startRead = busReq && grant && resp.ready && req.read;
	assign startWrite = busReq && grant && resp.ready && req.write;

	// **************************************************
	// state and idle history
	// **************************************************

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= ahbPkg::stateIdle;
			wasIdle <= 1'b1;
		end else begin
			state <= nextState;
			wasIdle <= ready;
		end
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			readData <= '0;
		end else if (state == ahbPkg::stateRdata && resp.ready) begin
			readData <= resp.rdata; // held until the next read
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			ahbPkg::stateIdle: begin
				if (startRead) begin
					nextState = ahbPkg::stateRaddr; // read wins over write
				end else if (startWrite) begin
					nextState = ahbPkg::stateWaddr;
				end
			end
			ahbPkg::stateRaddr: begin
				if (resp.ready) begin
					nextState = ahbPkg::stateRdata;
				end
			end
			ahbPkg::stateRdata: begin
				if (resp.ready) begin
					nextState = ahbPkg::stateIdle;
				end
			end
			ahbPkg::stateWaddr: begin
				if (resp.ready) begin
					nextState = ahbPkg::stateWdata;
				end
			end
			ahbPkg::stateWdata: begin
				if (resp.ready) begin
					nextState = ahbPkg::stateIdle;
				end
			end
			default: begin
				nextState = ahbPkg::stateIdle;
			end
		endcase
	end

	// **************************************************
	// bus outputs
	// **************************************************

	always_comb begin
		addrCtrl = '0;
		addrCtrl.trans = ahbPkg::transIdle;
		writeData = '0;
		case (state)
			ahbPkg::stateRaddr, ahbPkg::stateWaddr: begin
				addrCtrl.trans = ahbPkg::transNonseq;
				addrCtrl.write = (state == ahbPkg::stateWaddr);
				addrCtrl.size = `SIZ_32BIT;
				addrCtrl.burst = `BUR_SINGLE;
				addrCtrl.addr = req.address;
			end
			ahbPkg::stateWdata: begin
				writeData = req.writeData;
			end
			default: begin
				writeData = '0; // idle and read data phase drive nothing
			end
		endcase
	end

endmodule

// File: logic/ahbPkg.sv
package ahbPkg;

	// **************************************************
	// enums
	// **************************************************

	typedef enum logic [1:0] {
		transIdle   = 2'b00,
		transBusy   = 2'b01,
		transNonseq = 2'b10,
		transSeq    = 2'b11
	} htransE;

	typedef enum logic [2:0] {
		stateIdle  = 3'd0,
		stateRaddr = 3'd1,
		stateRdata = 3'd2,
		stateWaddr = 3'd3,
		stateWdata = 3'd4
	} masterStateE;

	// **************************************************
	// bus structs
	// **************************************************

	typedef struct packed {
		htransE      trans;
		logic        write;
		logic [2:0]  size;
		logic [2:0]  burst;
		logic [3:0]  prot;
		logic [31:0] addr;
	} ahbAddrCtrl; // address phase, 45 bits

	typedef struct packed {
		logic        ready;
		logic [1:0]  resp;
		logic [31:0] rdata;
	} ahbSlaveResp; // 35 bits

	typedef struct packed {
		logic        read;
		logic        write;
		logic        enable;
		logic [31:0] address;
		logic [31:0] writeData;
	} localReq; // 67 bits

endpackage

// File: include/ahb_params.svh
`ifndef AHB_PARAMS_SVH
`define AHB_PARAMS_SVH

// **************************************************
// AHB transfer encodings
// **************************************************

// HSIZE code for a 32-bit word
`define SIZ_32BIT 3'b010

// HBURST code for a single transfer
`define BUR_SINGLE 3'b000

// HRESP code for OKAY, the only response this slave gives
`define RESP_OKAY 2'b00

// **************************************************
// memory slave
// **************************************************

// depth in 32-bit words, a power of two
`define MEM_WORDS 64

// extra data-phase cycles per transfer, 0 is allowed
`define WAIT_STATES 2

`endif
